/* axil_pkg.sv */
package axil_pkg;

    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // ----------------------------------------
    // Channel payloads
    // ----------------------------------------
    typedef struct packed {
        axil_addr_t addr;
    } axil_aw_t;

    typedef struct packed {
        axil_data_t data;
        logic [3:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        axil_addr_t addr;
    } axil_ar_t;

    typedef struct packed {
        axil_data_t data;
        logic [1:0] resp;
    } axil_r_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam axil_addr_t REG_CTRL   = 4'h0;   // Read/write control
    localparam axil_addr_t REG_STATUS = 4'h4;   // Read-only status

endpackage

/* boot_regs.sv */
`timescale 1ns/1ps
module boot_regs
    import axil_pkg::*, multiboot_pkg::*;
(
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        awvalid,
    output logic        awready,
    input  axil_aw_t    aw,
    input  logic        wvalid,
    output logic        wready,
    input  axil_w_t     w,
    output logic        bvalid,
    input  logic        bready,
    output axil_b_t     b,
    input  logic        arvalid,
    output logic        arready,
    input  axil_ar_t    ar,
    output logic        rvalid,
    input  logic        rready,
    output axil_r_t     r,
    output boot_ctrl_t  boot_ctrl,
    input  seq_status_t seq_status
);

    logic       wr_go;
    logic       rd_go;
    logic       wr_hs;
    logic       rd_hs;
    axil_data_t rd_data;

    // Accept only with no response outstanding
    assign wr_go = awvalid && wvalid && !awready && !bvalid;
    assign rd_go = arvalid && !arready && !rvalid;
    assign wr_hs = awvalid && awready;
    assign rd_hs = arvalid && arready;

    // ----------------------------------------
    // Handshake and control register
    // ----------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            boot_ctrl <= '0;
        end
        else
        begin
            awready <= wr_go;   // One-cycle pulse on both channels
            wready  <= wr_go;
            arready <= rd_go;

            if (wr_hs)
            begin
                bvalid <= 1'b1;
                if (aw.addr == REG_CTRL && w.strb[0])
                begin
                    boot_ctrl.hotreset_en  <= w.data[0];
                    boot_ctrl.crc_check_en <= w.data[1];
                    boot_ctrl.slot         <= w.data[3:2];
                end
            end
            else if (bready)
            begin
                bvalid <= 1'b0;
            end

            if (rd_hs)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // ----------------------------------------
    // Read mux and response payloads
    // ----------------------------------------
    always_comb
    begin
        case (ar.addr)
            REG_CTRL:
                rd_data = {28'd0, boot_ctrl.slot, boot_ctrl.crc_check_en,
                           boot_ctrl.hotreset_en};
            REG_STATUS:
                rd_data = {29'd0, seq_status.golden_sel, seq_status.done,
                           seq_status.busy};   // Live view of the generator
            default:
                rd_data = '0;
        endcase
    end

    always_ff @(posedge sys_clk)
    begin
        if (wr_hs)
        begin
            if (aw.addr == REG_CTRL || aw.addr == REG_STATUS)
                b.resp <= RESP_OKAY;   // STATUS writes are dropped
            else
                b.resp <= RESP_SLVERR;
        end
        if (rd_hs)
        begin
            r.data <= rd_data;
            if (ar.addr == REG_CTRL || ar.addr == REG_STATUS)
                r.resp <= RESP_OKAY;
            else
                r.resp <= RESP_SLVERR;
        end
    end

    // Write response must wait for the host
    a_bvalid_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        bvalid && !bready |=> bvalid);

endmodule

/* cfg_port_serializer.sv */
`timescale 1ns/1ps
module cfg_port_serializer
    import multiboot_pkg::*;
#(
    parameter int CFG_WIDTH = 8
)
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 fifo_empty,
    input  cfg_word_t            fifo_dout,
    output logic                 rd_en,
    output logic                 cfg_cs_n,
    output logic                 cfg_rw_sel,
    output logic [CFG_WIDTH-1:0] cfg_data
);

    localparam int BEATS = 32 / CFG_WIDTH;
    localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

    logic [CNT_W-1:0]     beat_cnt;
    logic                 last_beat;
    logic [CFG_WIDTH-1:0] lane;

    assign last_beat = (beat_cnt == CNT_W'(BEATS - 1));
    assign rd_en     = !fifo_empty && last_beat;   // Pop with the final beat

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            beat_cnt <= '0;
        else if (fifo_empty || last_beat)
            beat_cnt <= '0;
        else
            beat_cnt <= beat_cnt + 1'b1;
    end

    // ----------------------------------------
    // Lane select, MSB first
    // ----------------------------------------
    generate
        if (CFG_WIDTH == 8)
        begin : g_x8
            always_comb
            begin
                case (beat_cnt)
                    2'd0:    lane = fifo_dout[31:24];
                    2'd1:    lane = fifo_dout[23:16];
                    2'd2:    lane = fifo_dout[15:8];
                    default: lane = fifo_dout[7:0];
                endcase
            end
        end
        else if (CFG_WIDTH == 16)
        begin : g_x16
            assign lane = beat_cnt[0] ? fifo_dout[15:0] : fifo_dout[31:16];
        end
        else
        begin : g_x32
            assign lane = fifo_dout;
        end
    endgenerate

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            cfg_cs_n   <= 1'b1;
            cfg_rw_sel <= 1'b1;   // Idle in read
            cfg_data   <= '0;
        end
        else
        begin
            cfg_cs_n   <= fifo_empty;
            cfg_rw_sel <= fifo_empty;   // Write while data flows
            if (!fifo_empty)
                cfg_data <= lane;
        end
    end

    a_cs_rw_match: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        cfg_cs_n == cfg_rw_sel);

endmodule

/* cmd_fifo.sv */
`timescale 1ns/1ps
module cmd_fifo
    import multiboot_pkg::*;
#(
    parameter int FIFO_DEPTH = 128
)
(
    input  logic      sys_clk,
    input  logic      sys_rst_n,
    input  logic      wr_en,
    input  cfg_word_t din,
    input  logic      rd_en,
    output cfg_word_t dout,
    output logic      full,
    output logic      empty
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    cfg_word_t     mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge sys_clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    assign dout  = mem[rd_ptr];   // Head word, no read latency
    assign full  = (count == CW'(FIFO_DEPTH));
    assign empty = (count == '0);

    a_no_underflow: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !(rd_en && empty));
    a_no_overflow: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !(wr_en && full));

endmodule

/* multiboot_pkg.sv */
package multiboot_pkg;

    // ----------------------------------------
    // Widths with a meaning
    // ----------------------------------------
    typedef logic [31:0] cfg_word_t;   // Configuration command word
    typedef logic [23:0] bs_addr_t;    // Flash start address
    typedef logic [1:0]  slot_t;       // 0 means no user image

    // ----------------------------------------
    // Configuration command words
    // ----------------------------------------
    localparam cfg_word_t FILL_WORD     = 32'hffff_ffff;
    localparam cfg_word_t SYNC_WORD     = 32'h0133_2d94;
    localparam cfg_word_t IRSTCTRL_REG  = 32'habc0_0001;   // Write one word to IRSTCTRL
    localparam cfg_word_t IRSTCTRL_DATA = 32'h0000_0000;
    localparam cfg_word_t IRSTADR_REG   = 32'hac00_0001;   // Write one word to IRSTADR
    localparam cfg_word_t CMD_REG       = 32'ha880_0001;   // Write one word to CMD
    localparam cfg_word_t IRSTCMD_DATA  = 32'h0000_000f;   // Warm boot restart
    localparam cfg_word_t NOP_WORD      = 32'ha000_0000;

    localparam bs_addr_t GOLDEN_ADDR = 24'h00_0000;   // Golden image sits at the bottom

    // ----------------------------------------
    // Control and status
    // ----------------------------------------
    typedef struct packed {
        logic  hotreset_en;
        logic  crc_check_en;
        slot_t slot;
    } boot_ctrl_t;

    typedef struct packed {
        logic valid;   // Verdict present
        logic error;   // Flash image failed CRC
    } crc_status_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic golden_sel;
    } seq_status_t;

endpackage

/* multiboot_top.sv */
`timescale 1ns/1ps
module multiboot_top
    import axil_pkg::*, multiboot_pkg::*;
#(
    parameter int       USER_SLOTS = 3,
    parameter bs_addr_t SLOT1_ADDR = 24'h20_b000,
    parameter bs_addr_t SLOT2_ADDR = 24'h41_0000,
    parameter bs_addr_t SLOT3_ADDR = 24'h61_5000,
    parameter int       FILL_WORDS = 100,
    parameter int       NOP_WORDS  = 10,
    parameter int       CFG_WIDTH  = 8,    // 8, 16 or 32
    parameter int       FIFO_DEPTH = 128   // Must hold the whole stream
)
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 awvalid,
    output logic                 awready,
    input  axil_aw_t             aw,
    input  logic                 wvalid,
    output logic                 wready,
    input  axil_w_t              w,
    output logic                 bvalid,
    input  logic                 bready,
    output axil_b_t              b,
    input  logic                 arvalid,
    output logic                 arready,
    input  axil_ar_t             ar,
    output logic                 rvalid,
    input  logic                 rready,
    output axil_r_t              r,
    input  logic                 open_sw_code_done,
    input  crc_status_t          crc_status,
    output logic                 cfg_cs_n,
    output logic                 cfg_rw_sel,
    output logic [CFG_WIDTH-1:0] cfg_data
);

    boot_ctrl_t  boot_ctrl;
    seq_status_t seq_status;
    logic        wr_en;
    logic        rd_en;
    logic        fifo_full;
    logic        fifo_empty;
    cfg_word_t   wr_data;
    cfg_word_t   fifo_dout;

    boot_regs u_boot_regs (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .bvalid     (bvalid),
        .bready     (bready),
        .b          (b),
        .arvalid    (arvalid),
        .arready    (arready),
        .ar         (ar),
        .rvalid     (rvalid),
        .rready     (rready),
        .r          (r),
        .boot_ctrl  (boot_ctrl),
        .seq_status (seq_status)
    );

    reboot_seq_gen #(
        .USER_SLOTS (USER_SLOTS),
        .SLOT1_ADDR (SLOT1_ADDR),
        .SLOT2_ADDR (SLOT2_ADDR),
        .SLOT3_ADDR (SLOT3_ADDR),
        .FILL_WORDS (FILL_WORDS),
        .NOP_WORDS  (NOP_WORDS)
    ) u_reboot_seq_gen (
        .sys_clk           (sys_clk),
        .sys_rst_n         (sys_rst_n),
        .boot_ctrl         (boot_ctrl),
        .crc_status        (crc_status),
        .open_sw_code_done (open_sw_code_done),
        .fifo_full         (fifo_full),
        .fifo_empty        (fifo_empty),
        .wr_en             (wr_en),
        .wr_data           (wr_data),
        .seq_status        (seq_status)
    );

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cmd_fifo (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .wr_en     (wr_en),
        .din       (wr_data),
        .rd_en     (rd_en),
        .dout      (fifo_dout),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    cfg_port_serializer #(
        .CFG_WIDTH (CFG_WIDTH)
    ) u_cfg_port_serializer (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .fifo_empty (fifo_empty),
        .fifo_dout  (fifo_dout),
        .rd_en      (rd_en),
        .cfg_cs_n   (cfg_cs_n),
        .cfg_rw_sel (cfg_rw_sel),
        .cfg_data   (cfg_data)
    );

endmodule

/* project.f */
multiboot_pkg.sv
axil_pkg.sv
boot_regs.sv
reboot_seq_gen.sv
cmd_fifo.sv
cfg_port_serializer.sv
multiboot_top.sv
tb_multiboot_top.sv

/* reboot_seq_gen.sv */
`timescale 1ns/1ps
module reboot_seq_gen
    import multiboot_pkg::*;
#(
    parameter int       USER_SLOTS = 3,
    parameter bs_addr_t SLOT1_ADDR = 24'h20_b000,
    parameter bs_addr_t SLOT2_ADDR = 24'h41_0000,
    parameter bs_addr_t SLOT3_ADDR = 24'h61_5000,
    parameter int       FILL_WORDS = 100,
    parameter int       NOP_WORDS  = 10
)
(
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  boot_ctrl_t  boot_ctrl,
    input  crc_status_t crc_status,
    input  logic        open_sw_code_done,
    input  logic        fifo_full,
    input  logic        fifo_empty,
    output logic        wr_en,
    output cfg_word_t   wr_data,
    output seq_status_t seq_status
);

    localparam int TOTAL = FILL_WORDS + 7 + NOP_WORDS;   // 117 by default
    localparam int CNT_W = $clog2(TOTAL + 1);

    typedef enum logic [2:0] {IDLE, FILL, CMD, NOP, DONE} seq_state_t;

    seq_state_t       state;
    logic [1:0]       done_sync;
    logic             trigger;
    logic             emit;
    logic [CNT_W-1:0] idx;
    logic [CNT_W-1:0] next_idx;
    logic [2:0]       cmd_ofs;
    logic             golden_sel;
    logic             busy;
    bs_addr_t         slot_addr;
    bs_addr_t         start_addr;
    cfg_word_t        cur_word;

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            done_sync <= 2'b00;
        else
            done_sync <= {done_sync[0], open_sw_code_done};   // 2-flop synchronizer
    end

    assign trigger = done_sync[1] && boot_ctrl.hotreset_en;

    // ----------------------------------------
    // Start address selection
    // ----------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            golden_sel <= 1'b0;
        else if (!boot_ctrl.crc_check_en)
            golden_sel <= 1'b0;
        else if (crc_status.valid)
            golden_sel <= crc_status.error;
    end

    always_comb
    begin
        case (boot_ctrl.slot)
            2'd1:    slot_addr = SLOT1_ADDR;
            2'd2:    slot_addr = (USER_SLOTS >= 2) ? SLOT2_ADDR : GOLDEN_ADDR;
            2'd3:    slot_addr = (USER_SLOTS >= 3) ? SLOT3_ADDR : GOLDEN_ADDR;
            default: slot_addr = GOLDEN_ADDR;   // No user image
        endcase
    end

    assign start_addr = golden_sel ? GOLDEN_ADDR : slot_addr;

    // ----------------------------------------
    // Command word for the current index
    // ----------------------------------------
    assign next_idx = idx + 1'b1;
    assign cmd_ofs  = 3'(idx - CNT_W'(FILL_WORDS));

    always_comb
    begin
        if (idx < FILL_WORDS)
            cur_word = FILL_WORD;
        else if (idx >= FILL_WORDS + 7)
            cur_word = NOP_WORD;
        else
        begin
            case (cmd_ofs)
                3'd0:    cur_word = SYNC_WORD;
                3'd1:    cur_word = IRSTCTRL_REG;
                3'd2:    cur_word = IRSTCTRL_DATA;
                3'd3:    cur_word = IRSTADR_REG;
                3'd4:    cur_word = cfg_word_t'(start_addr);   // Zero-extended
                3'd5:    cur_word = CMD_REG;
                default: cur_word = IRSTCMD_DATA;
            endcase
        end
    end

    assign emit = (state == IDLE) ? trigger : (state inside {FILL, CMD, NOP});

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            state   <= IDLE;
            idx     <= '0;
            wr_en   <= 1'b0;
            wr_data <= '0;
            busy    <= 1'b0;
        end
        else
        begin
            wr_en <= emit;
            if (emit)
            begin
                wr_data <= cur_word;
                idx     <= next_idx;   // Stops at TOTAL once DONE
                if (idx == CNT_W'(TOTAL - 1))
                    state <= DONE;
                else if (next_idx < FILL_WORDS)
                    state <= FILL;
                else if (next_idx < FILL_WORDS + 7)
                    state <= CMD;
                else
                    state <= NOP;
            end

            if (state == IDLE && trigger)
                busy <= 1'b1;
            else if (state == DONE && !wr_en && fifo_empty)
                busy <= 1'b0;   // Stream fully handed to the port
        end
    end

    assign seq_status = '{busy: busy, done: (state == DONE), golden_sel: golden_sel};

    // FIFO is sized for the whole stream
    a_no_backpressure: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !(wr_en && fifo_full));

endmodule

/* tb_multiboot_top.sv */
`timescale 1ns/1ps
module tb_multiboot_top
    import axil_pkg::*, multiboot_pkg::*;
();

    localparam bs_addr_t T_SLOT1_ADDR  = 24'h10_0000;
    localparam bs_addr_t T_SLOT2_ADDR  = 24'h38_4000;
    localparam bs_addr_t T_SLOT3_ADDR  = 24'h5a_8000;
    localparam int       FILL_WORDS    = 100;
    localparam int       NOP_WORDS     = 10;
    localparam int       STREAM_WORDS  = FILL_WORDS + 7 + NOP_WORDS;
    localparam int       BOOT_CYCLES   = STREAM_WORDS * 4;   // One byte beat per cycle
    // Four boots, the idle window and register traffic, with margin
    localparam int       TIMEOUT_CYCLES = 4 * BOOT_CYCLES + 2128;

    logic        sys_clk = 1'b0;
    logic        sys_rst_n;
    logic        awvalid;
    logic        awready;
    axil_aw_t    aw;
    logic        wvalid;
    logic        wready;
    axil_w_t     w;
    logic        bvalid;
    logic        bready;
    axil_b_t     b;
    logic        arvalid;
    logic        arready;
    axil_ar_t    ar;
    logic        rvalid;
    logic        rready;
    axil_r_t     r;
    logic        open_sw_code_done;
    crc_status_t crc_status;
    logic        cfg_cs_n;
    logic        cfg_rw_sel;
    logic [7:0]  cfg_data;

    cfg_word_t   captured [$];
    cfg_word_t   expected [$];
    cfg_word_t   word_acc;
    int          beat_idx;
    int          beat_total;
    int          rw_mismatch;
    int          checks;
    int          errors;
    int          cycles;
    integer      seed;

    multiboot_top #(
        .USER_SLOTS (3),
        .SLOT1_ADDR (T_SLOT1_ADDR),
        .SLOT2_ADDR (T_SLOT2_ADDR),
        .SLOT3_ADDR (T_SLOT3_ADDR),
        .FILL_WORDS (FILL_WORDS),
        .NOP_WORDS  (NOP_WORDS),
        .CFG_WIDTH  (8),
        .FIFO_DEPTH (128)
    ) uut (
        .sys_clk           (sys_clk),
        .sys_rst_n         (sys_rst_n),
        .awvalid           (awvalid),
        .awready           (awready),
        .aw                (aw),
        .wvalid            (wvalid),
        .wready            (wready),
        .w                 (w),
        .bvalid            (bvalid),
        .bready            (bready),
        .b                 (b),
        .arvalid           (arvalid),
        .arready           (arready),
        .ar                (ar),
        .rvalid            (rvalid),
        .rready            (rready),
        .r                 (r),
        .open_sw_code_done (open_sw_code_done),
        .crc_status        (crc_status),
        .cfg_cs_n          (cfg_cs_n),
        .cfg_rw_sel        (cfg_rw_sel),
        .cfg_data          (cfg_data)
    );

    always #10 sys_clk = ~sys_clk;   // 20 ns period

    always @(posedge sys_clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT never finished a test", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Config port monitor
    // ----------------------------------------
    always @(negedge sys_clk)
    begin
        if (!sys_rst_n)
            beat_idx = 0;
        else
        begin
            if (cfg_rw_sel !== cfg_cs_n)
                rw_mismatch++;   // Write select follows chip select
            if (!cfg_cs_n)
            begin
                word_acc = {word_acc[23:0], cfg_data};   // MSB beat arrives first
                beat_total++;
                if (beat_idx == 3)
                begin
                    captured.push_back(word_acc);
                    beat_idx = 0;
                end
                else
                    beat_idx++;
            end
        end
    end

    task check(input string name, input logic [31:0] exp_val, input logic [31:0] act_val);
        checks++;
        if (act_val !== exp_val)
        begin
            errors++;
            $display("ERR %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
        end
    endtask

    task report_test(input string name, input int err_before);
        $display("%-12s %s (%0d errors)", name, (errors == err_before) ? "ok" : "FAIL",
                 errors - err_before);
    endtask

    task reset_dut();
        @(posedge sys_clk);
        sys_rst_n         <= 1'b0;
        open_sw_code_done <= 1'b0;
        crc_status        <= '0;
        repeat (5) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        @(posedge sys_clk);
    endtask

    // ----------------------------------------
    // AXI4-Lite host
    // ----------------------------------------
    task axil_write(input axil_addr_t addr, input axil_data_t data, input logic [3:0] strb,
                    output logic [1:0] resp);
        @(posedge sys_clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        aw      <= '{addr: addr};
        w       <= '{data: data, strb: strb};
        bready  <= 1'b1;
        @(negedge sys_clk);
        while (!(awready && wready))
            @(negedge sys_clk);
        @(posedge sys_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge sys_clk);
        while (!bvalid)
            @(negedge sys_clk);
        resp = b.resp;
        @(posedge sys_clk);
        bready <= 1'b0;
    endtask

    task axil_read(input axil_addr_t addr, output axil_data_t data, output logic [1:0] resp);
        @(posedge sys_clk);
        arvalid <= 1'b1;
        ar      <= '{addr: addr};
        rready  <= 1'b1;
        @(negedge sys_clk);
        while (!arready)
            @(negedge sys_clk);
        @(posedge sys_clk);
        arvalid <= 1'b0;
        @(negedge sys_clk);
        while (!rvalid)
            @(negedge sys_clk);
        data = r.data;
        resp = r.resp;
        @(posedge sys_clk);
        rready <= 1'b0;
    endtask

    // Expected command stream for a given start address
    task build_expected(input bs_addr_t addr);
        expected.delete();
        repeat (FILL_WORDS) expected.push_back(FILL_WORD);
        expected.push_back(SYNC_WORD);
        expected.push_back(IRSTCTRL_REG);
        expected.push_back(IRSTCTRL_DATA);
        expected.push_back(IRSTADR_REG);
        expected.push_back({8'h00, addr});
        expected.push_back(CMD_REG);
        expected.push_back(IRSTCMD_DATA);
        repeat (NOP_WORDS) expected.push_back(NOP_WORD);
    endtask

    task compare_stream(input string name);
        int n;
        n = (captured.size() < expected.size()) ? captured.size() : expected.size();
        check({name, " word count"}, expected.size(), captured.size());
        check({name, " rw_sel"}, 0, rw_mismatch);
        for (int i = 0; i < n; i++)
            check($sformatf("%s word %0d", name, i), expected[i], captured[i]);
    endtask

    task wait_seq_done(output axil_data_t status);
        logic [1:0] resp;
        status = '0;
        while (status[1:0] !== 2'b10)   // done set, busy clear
            axil_read(REG_STATUS, status, resp);
    endtask

    task boot_and_capture(input logic [3:0] ctrl, input crc_status_t crc,
                          output axil_data_t status);
        logic [1:0] resp;
        reset_dut();
        crc_status <= crc;
        captured.delete();
        beat_total  = 0;
        rw_mismatch = 0;
        axil_write(REG_CTRL, {28'd0, ctrl}, 4'h1, resp);   // Arm before done rises
        @(posedge sys_clk);
        open_sw_code_done <= 1'b1;
        wait_seq_done(status);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task test_reg_access();
        int         err0;
        axil_data_t rdata;
        axil_data_t val;
        logic [1:0] resp;
        err0 = errors;
        reset_dut();
        repeat (4)
        begin
            val = $random(seed) & 32'hf;
            axil_write(REG_CTRL, val, 4'h1, resp);
            check("reg_access ctrl write resp", RESP_OKAY, resp);
            axil_read(REG_CTRL, rdata, resp);
            check("reg_access ctrl readback", val, rdata);
        end
        axil_write(REG_CTRL, ~val, 4'he, resp);   // Lane 0 strobe off
        axil_read(REG_CTRL, rdata, resp);
        check("reg_access ctrl strb", val, rdata);
        axil_write(REG_STATUS, 32'h7, 4'hf, resp);
        check("reg_access status write resp", RESP_OKAY, resp);
        axil_read(REG_STATUS, rdata, resp);
        check("reg_access status value", 32'h0, rdata);
        axil_write(4'h8, 32'h5, 4'hf, resp);
        check("reg_access unmapped write", RESP_SLVERR, resp);
        axil_read(4'hc, rdata, resp);
        check("reg_access unmapped read", RESP_SLVERR, resp);
        report_test("reg_access", err0);
    endtask

    task test_boot(input string name, input logic [3:0] ctrl, input crc_status_t crc,
                   input bs_addr_t exp_addr, input logic [2:0] exp_status);
        int         err0;
        axil_data_t status;
        err0 = errors;
        boot_and_capture(ctrl, crc, status);
        build_expected(exp_addr);
        compare_stream(name);
        check({name, " status"}, {29'd0, exp_status}, status);
        report_test(name, err0);
    endtask

    task test_slot0();
        int         err0;
        axil_data_t status;
        logic [1:0] resp;
        err0 = errors;
        reset_dut();
        captured.delete();
        beat_total  = 0;
        rw_mismatch = 0;
        axil_write(REG_CTRL, 32'h0, 4'h1, resp);   // Slot 0, hot reset not armed
        @(posedge sys_clk);
        open_sw_code_done <= 1'b1;
        repeat (200) @(posedge sys_clk);
        check("no_trigger beats", 0, beat_total);
        axil_read(REG_STATUS, status, resp);
        check("no_trigger status", 32'h0, status);
        axil_write(REG_CTRL, 32'h1, 4'h1, resp);   // Arm with slot 0
        wait_seq_done(status);
        build_expected(GOLDEN_ADDR);
        compare_stream("slot0");
        check("slot0 addr word", 32'h0, (captured.size() > FILL_WORDS + 4) ?
              captured[FILL_WORDS + 4] : 32'hdead_beef);
        report_test("slot0", err0);
    endtask

    initial
    begin
        sys_rst_n         = 1'b0;
        awvalid           = 1'b0;
        aw                = '0;
        wvalid            = 1'b0;
        w                 = '0;
        bready            = 1'b0;
        arvalid           = 1'b0;
        ar                = '0;
        rready            = 1'b0;
        open_sw_code_done = 1'b0;
        crc_status        = '0;
        word_acc          = '0;
        beat_idx          = 0;
        beat_total        = 0;
        rw_mismatch       = 0;
        checks            = 0;
        errors            = 0;
        cycles            = 0;
        seed              = 66852;

        test_reg_access();
        test_boot("user_boot", 4'b1001, '{valid: 1'b0, error: 1'b0}, T_SLOT2_ADDR, 3'b010);
        test_boot("crc_golden", 4'b1011, '{valid: 1'b1, error: 1'b1}, GOLDEN_ADDR, 3'b110);
        test_boot("crc_ignored", 4'b1001, '{valid: 1'b1, error: 1'b1}, T_SLOT2_ADDR, 3'b010);
        test_slot0();

        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
